// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_stack_mem
FILELIST  ?= project.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and search the log for the result"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bank_array.sv ====
`default_nettype none

module bank_array
  import mem_geom_pkg::*;
#(
  parameter int NUMWROW    = mem_geom_pkg::NUMWROW,
  parameter int SRAM_DELAY = 2
) (
  input logic       clk,
  bank_port_if.bank port
);

  typedef logic [NUMRDPT-1:0][WIDTH-1:0] rd_word_t;

  logic [WIDTH-1:0]              mem [NUMWROW];
  logic [NUMWRPT-1:0][WIDTH-1:0] wr_word;
  rd_word_t                      rd_word;
  rd_word_t                      rd_dly;

  // Each port's word already holds the lower ports' bits for a shared row.
  always_comb begin
    for (int p = 0; p < NUMWRPT; p++) begin
      wr_word[p] = mem[port.mem_wr_adr[p]];
      for (int q = 0; q <= p; q++) begin
        if (port.mem_write[q] && (port.mem_wr_adr[q] == port.mem_wr_adr[p])) begin
          wr_word[p] = (port.mem_din[q] & port.mem_bw[q]) | (wr_word[p] & ~port.mem_bw[q]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUMWRPT; p++) begin
      if (port.mem_write[p]) begin
        mem[port.mem_wr_adr[p]] <= wr_word[p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUMRDPT; p++) begin
      rd_word[p] = port.mem_read[p] ? mem[port.mem_rd_adr[p]] : '0;  // Old contents.
    end
  end

  delay_line #(
    .T     (rd_word_t),
    .DEPTH (SRAM_DELAY)
  ) u_rd_dly (
    .clk (clk),
    .rst (1'b0),
    .d   (rd_word),
    .q   (rd_dly)
  );

  assign port.mem_rd_dout = rd_dly;

endmodule

`default_nettype wire

// ==== bank_port_if.sv ====
`default_nettype none

interface bank_port_if
  import mem_geom_pkg::*;
();

  logic [NUMWRPT-1:0]              mem_write;
  logic [NUMWRPT-1:0][BITWROW-1:0] mem_wr_adr;
  logic [NUMWRPT-1:0][WIDTH-1:0]   mem_bw;
  logic [NUMWRPT-1:0][WIDTH-1:0]   mem_din;
  logic [NUMRDPT-1:0]              mem_read;
  logic [NUMRDPT-1:0][BITWROW-1:0] mem_rd_adr;
  logic [NUMRDPT-1:0][WIDTH-1:0]   mem_rd_dout;    // SRAM_DELAY cycles after mem_read.

  modport ctrl (
    output mem_write, mem_wr_adr, mem_bw, mem_din,
    output mem_read, mem_rd_adr,
    input  mem_rd_dout
  );

  modport bank (
    input  mem_write, mem_wr_adr, mem_bw, mem_din,
    input  mem_read, mem_rd_adr,
    output mem_rd_dout
  );

endinterface

`default_nettype wire

// ==== cmd_stage.sv ====
`default_nettype none

module cmd_stage
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
#(
  parameter int WIDTH   = mem_geom_pkg::WIDTH,
  parameter int NUMADDR = mem_geom_pkg::NUMADDR,
  parameter int NUMWBNK = mem_geom_pkg::NUMWBNK,
  parameter int NUMWROW = mem_geom_pkg::NUMWROW
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_adr,
  input  logic [NUMWRPT*WIDTH-1:0]   bw,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  bank_port_if.ctrl                  banks [NUMWBNK],
  output rd_tag_vec_t                rd_tag
);

  wr_cmd_t [NUMWRPT-1:0] wr_d;
  wr_cmd_t [NUMWRPT-1:0] wr_q;
  rd_tag_vec_t           rd_d;
  rd_tag_vec_t           rd_q;

  always_comb begin
    for (int w = 0; w < NUMWRPT; w++) begin
      wr_d[w].vld  = write[w] && (wr_adr[w*BITADDR +: BITADDR] < NUMADDR);
      wr_d[w].bank = addr_bank(wr_adr[w*BITADDR +: BITADDR], NUMWROW);
      wr_d[w].row  = addr_row(wr_adr[w*BITADDR +: BITADDR], NUMWROW);
      wr_d[w].bw   = bw[w*WIDTH +: WIDTH];
      wr_d[w].data = din[w*WIDTH +: WIDTH];
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_d[r].vld      = read[r] && (rd_adr[r*BITADDR +: BITADDR] < NUMADDR);
      rd_d[r].bank     = addr_bank(rd_adr[r*BITADDR +: BITADDR], NUMWROW);
      rd_d[r].row      = addr_row(rd_adr[r*BITADDR +: BITADDR], NUMWROW);
      rd_d[r].fwd      = 1'b0;
      rd_d[r].fwd_bw   = '0;
      rd_d[r].fwd_data = '0;
      for (int w = 0; w < NUMWRPT; w++) begin   // Port order, so the higher port wins.
        if (rd_d[r].vld && wr_d[w].vld &&
            (wr_adr[w*BITADDR +: BITADDR] == rd_adr[r*BITADDR +: BITADDR])) begin
          rd_d[r].fwd      = 1'b1;
          rd_d[r].fwd_bw   = rd_d[r].fwd_bw | wr_d[w].bw;
          rd_d[r].fwd_data = (wr_d[w].data & wr_d[w].bw) | (rd_d[r].fwd_data & ~wr_d[w].bw);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_q <= wr_d;
    rd_q <= rd_d;
    if (rst) begin
      for (int w = 0; w < NUMWRPT; w++) begin
        wr_q[w].vld <= 1'b0;
      end
      for (int r = 0; r < NUMRDPT; r++) begin
        rd_q[r].vld <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Bank steering
  //////////////////////////////

  for (genvar b = 0; b < NUMWBNK; b++) begin : g_bank
    for (genvar w = 0; w < NUMWRPT; w++) begin : g_wr
      assign banks[b].mem_write[w]  = wr_q[w].vld && (wr_q[w].bank == b);
      assign banks[b].mem_wr_adr[w] = wr_q[w].row;
      assign banks[b].mem_bw[w]     = wr_q[w].bw;
      assign banks[b].mem_din[w]    = wr_q[w].data;
    end
    for (genvar r = 0; r < NUMRDPT; r++) begin : g_rd
      assign banks[b].mem_read[r]   = rd_q[r].vld && (rd_q[r].bank == b);
      assign banks[b].mem_rd_adr[r] = rd_q[r].row;
    end
  end

  assign rd_tag = rd_q;

endmodule

`default_nettype wire

// ==== delay_line.sv ====
`default_nettype none

module delay_line #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic rst,
  input  T     d,
  output T     q
);

  T pipe [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign q = pipe[DEPTH-1];

endmodule

`default_nettype wire

// ==== mem_geom_pkg.sv ====
`default_nettype none

package mem_geom_pkg;

  //////////////////////////////
  // Memory shape
  //////////////////////////////

  localparam int WIDTH   = 32;
  localparam int NUMADDR = 1000;
  localparam int BITADDR = $clog2(NUMADDR);
  localparam int NUMWBNK = 4;
  localparam int BITWBNK = $clog2(NUMWBNK);
  localparam int NUMWROW = 250;                    // Need not be a power of two.
  localparam int BITWROW = $clog2(NUMWROW);
  localparam int NUMRDPT = 2;
  localparam int NUMWRPT = 2;
  localparam int BITPADR = BITWBNK + BITWROW;      // Bank on top, row below.

  //////////////////////////////
  // Address split
  //////////////////////////////

  function automatic logic [BITWBNK-1:0] addr_bank(input logic [BITADDR-1:0] addr,
                                                   input int unsigned nrow = NUMWROW);
    return BITWBNK'(addr / nrow);
  endfunction

  function automatic logic [BITWROW-1:0] addr_row(input logic [BITADDR-1:0] addr,
                                                  input int unsigned nrow = NUMWROW);
    return BITWROW'(addr % nrow);
  endfunction

endpackage

`default_nettype wire

// ==== mem_port_pkg.sv ====
`default_nettype none

package mem_port_pkg;
  import mem_geom_pkg::*;

  // One write port's command after the command register.
  typedef struct packed {
    logic               vld;
    logic [BITWBNK-1:0] bank;
    logic [BITWROW-1:0] row;
    logic [WIDTH-1:0]   bw;
    logic [WIDTH-1:0]   data;
  } wr_cmd_t;

  // Follows a read through the bank latency to the output select.
  typedef struct packed {
    logic               vld;
    logic [BITWBNK-1:0] bank;
    logic [BITWROW-1:0] row;
    logic               fwd;
    logic [WIDTH-1:0]   fwd_bw;                    // Bits written in the read's own cycle.
    logic [WIDTH-1:0]   fwd_data;
  } rd_tag_t;

  typedef rd_tag_t [NUMRDPT-1:0] rd_tag_vec_t;

endpackage

`default_nettype wire

// ==== project.f ====
mem_geom_pkg.sv
mem_port_pkg.sv
bank_port_if.sv
delay_line.sv
cmd_stage.sv
bank_array.sv
rd_out_stage.sv
stack_mem_top.sv
tb_shadow_check.sv
tb_stack_mem.sv

// ==== rd_out_stage.sv ====
`default_nettype none

module rd_out_stage
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
#(
  parameter int WIDTH   = mem_geom_pkg::WIDTH,
  parameter int NUMWBNK = mem_geom_pkg::NUMWBNK
) (
  input  logic                       clk,
  input  logic                       rst,
  input  rd_tag_vec_t                tag,
  bank_port_if.ctrl                  banks [NUMWBNK],
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout,
  output logic [NUMRDPT-1:0]         rd_fwrd,
  output logic [NUMRDPT*BITPADR-1:0] rd_padr
);

  logic [NUMRDPT-1:0][WIDTH-1:0] bank_dout [NUMWBNK];
  logic [NUMRDPT-1:0][WIDTH-1:0] sel_dout;

  for (genvar b = 0; b < NUMWBNK; b++) begin : g_bank
    assign bank_dout[b] = banks[b].mem_rd_dout;
  end

  // Forwarded bits replace the stale bank word.
  always_comb begin
    for (int p = 0; p < NUMRDPT; p++) begin
      sel_dout[p] = bank_dout[tag[p].bank][p];
      sel_dout[p] = (sel_dout[p] & ~tag[p].fwd_bw) | (tag[p].fwd_data & tag[p].fwd_bw);
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUMRDPT; p++) begin
      rd_dout[p*WIDTH +: WIDTH]     <= sel_dout[p];
      rd_padr[p*BITPADR +: BITPADR] <= {tag[p].bank, tag[p].row};
    end
    if (rst) begin
      rd_vld  <= '0;
      rd_fwrd <= '0;
    end else begin
      for (int p = 0; p < NUMRDPT; p++) begin
        rd_vld[p]  <= tag[p].vld;
        rd_fwrd[p] <= tag[p].vld && tag[p].fwd;
      end
    end
  end

endmodule

`default_nettype wire

// ==== stack_mem_top.sv ====
`default_nettype none

module stack_mem_top
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
#(
  parameter int WIDTH      = mem_geom_pkg::WIDTH,
  parameter int NUMADDR    = mem_geom_pkg::NUMADDR,
  parameter int NUMWBNK    = mem_geom_pkg::NUMWBNK,
  parameter int NUMWROW    = mem_geom_pkg::NUMWROW,
  parameter int SRAM_DELAY = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_adr,
  input  logic [NUMWRPT*WIDTH-1:0]   bw,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout,
  output logic [NUMRDPT-1:0]         rd_fwrd,
  output logic [NUMRDPT*BITPADR-1:0] rd_padr
);

  bank_port_if banks [NUMWBNK] ();

  rd_tag_vec_t cmd_tag;
  rd_tag_vec_t out_tag;                            // Lines up with the bank read data.

  cmd_stage #(
    .WIDTH   (WIDTH),
    .NUMADDR (NUMADDR),
    .NUMWBNK (NUMWBNK),
    .NUMWROW (NUMWROW)
  ) u_cmd (
    .clk    (clk),
    .rst    (rst),
    .write  (write),
    .wr_adr (wr_adr),
    .bw     (bw),
    .din    (din),
    .read   (read),
    .rd_adr (rd_adr),
    .banks  (banks),
    .rd_tag (cmd_tag)
  );

  for (genvar b = 0; b < NUMWBNK; b++) begin : g_bank
    bank_array #(
      .NUMWROW    (NUMWROW),
      .SRAM_DELAY (SRAM_DELAY)
    ) u_bank (
      .clk  (clk),
      .port (banks[b])
    );
  end

  delay_line #(
    .T     (rd_tag_vec_t),
    .DEPTH (SRAM_DELAY)
  ) u_tag_dly (
    .clk (clk),
    .rst (rst),
    .d   (cmd_tag),
    .q   (out_tag)
  );

  rd_out_stage #(
    .WIDTH   (WIDTH),
    .NUMWBNK (NUMWBNK)
  ) u_out (
    .clk     (clk),
    .rst     (rst),
    .tag     (out_tag),
    .banks   (banks),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .rd_padr (rd_padr)
  );

endmodule

`default_nettype wire

// ==== tb_shadow_check.sv ====
`default_nettype none

module tb_shadow_check
  import mem_geom_pkg::*;
#(
  parameter int SRAM_DELAY = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [NUMWRPT-1:0]         write,
  input  logic [NUMWRPT*BITADDR-1:0] wr_adr,
  input  logic [NUMWRPT*WIDTH-1:0]   bw,
  input  logic [NUMWRPT*WIDTH-1:0]   din,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  input  logic [NUMRDPT-1:0]         rd_vld,
  input  logic [NUMRDPT*WIDTH-1:0]   rd_dout,
  input  logic [NUMRDPT-1:0]         rd_fwrd,
  input  logic [NUMRDPT*BITPADR-1:0] rd_padr,
  output int                         err_cnt,
  output int                         miss_cnt
);

  typedef struct {
    int               due;
    int               port;
    int               addr;
    logic [WIDTH-1:0] data;
    logic             fwd;
  } exp_t;

  logic [WIDTH-1:0] model [NUMADDR];                 // Shadow copy of every word.
  exp_t             exp_q [$];
  int               cyc;

  initial begin
    err_cnt  = 0;
    miss_cnt = 0;
    cyc      = 0;
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Bank number in the upper bits, row number in the lower bits.
  function automatic int padr_of(input int a);
    return ((a / NUMWROW) << BITWROW) | (a % NUMWROW);
  endfunction

  function automatic logic [WIDTH-1:0] merge(input logic [WIDTH-1:0] old_word,
                                             input logic [WIDTH-1:0] new_word,
                                             input logic [WIDTH-1:0] mask);
    return (new_word & mask) | (old_word & ~mask);
  endfunction

  //////////////////////////////
  // Inputs and outputs are both stable at the falling edge.
  //////////////////////////////

  always @(negedge clk) begin
    exp_t               e;
    logic [NUMRDPT-1:0] seen;
    logic [WIDTH-1:0]   word;
    logic               fwd;
    int                 a;
    int                 wa;
    seen = '0;
    while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      seen[e.port] = 1'b1;
      if (rd_vld[e.port] !== 1'b1) begin
        miss_cnt++;
        $display("Read of address %0d on port %0d never returned a result.", e.addr, e.port);
      end else begin
        check($sformatf("rd_dout[%0d] for address %0d", e.port, e.addr),
              64'(rd_dout[e.port*WIDTH +: WIDTH]), 64'(e.data));
        check($sformatf("rd_fwrd[%0d] for address %0d", e.port, e.addr),
              64'(rd_fwrd[e.port]), 64'(e.fwd));
        check($sformatf("rd_padr[%0d] for address %0d", e.port, e.addr),
              64'(rd_padr[e.port*BITPADR +: BITPADR]), 64'(padr_of(e.addr)));
      end
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      if (!seen[p] && rd_vld[p] !== 1'b0) begin
        miss_cnt++;
        $display("Port %0d gave a read result at time %0t with no read due.", p, $time);
      end
    end
    if (!rst) begin
      for (int p = 0; p < NUMRDPT; p++) begin
        if (read[p]) begin
          a    = int'(rd_adr[p*BITADDR +: BITADDR]);
          word = model[a];                             // Contents before this cycle's writes.
          fwd  = 1'b0;
          for (int w = 0; w < NUMWRPT; w++) begin
            wa = int'(wr_adr[w*BITADDR +: BITADDR]);
            if (write[w] && wa == a) begin
              fwd  = 1'b1;
              word = merge(word, din[w*WIDTH +: WIDTH], bw[w*WIDTH +: WIDTH]);
            end
          end
          e.due  = cyc + SRAM_DELAY + 2;
          e.port = p;
          e.addr = a;
          e.data = word;
          e.fwd  = fwd;
          exp_q.push_back(e);
        end
      end
      for (int w = 0; w < NUMWRPT; w++) begin        // Higher port last, so it wins.
        if (write[w]) begin
          wa        = int'(wr_adr[w*BITADDR +: BITADDR]);
          model[wa] = merge(model[wa], din[w*WIDTH +: WIDTH], bw[w*WIDTH +: WIDTH]);
        end
      end
    end
    cyc++;
  end

endmodule

`default_nettype wire

// ==== tb_stack_mem.sv ====
`default_nettype none

module tb_stack_mem
  import mem_geom_pkg::*;
();

  localparam int               SRAM_DELAY = 2;
  localparam int               CLK_PERIOD = 4;
  localparam logic [WIDTH-1:0] FULL       = '1;

  typedef struct {
    logic [1:0]       wr;
    int               wa0;
    logic [WIDTH-1:0] bw0;
    logic [WIDTH-1:0] d0;
    int               wa1;
    logic [WIDTH-1:0] bw1;
    logic [WIDTH-1:0] d1;
    logic [1:0]       rd;
    int               ra0;
    int               ra1;
    bit               rnd;                           // Replace d0 and d1 by LFSR words.
  } row_t;

  logic                       clk = 1'b0;
  logic                       rst;
  logic [NUMWRPT-1:0]         write;
  logic [NUMWRPT*BITADDR-1:0] wr_adr;
  logic [NUMWRPT*WIDTH-1:0]   bw;
  logic [NUMWRPT*WIDTH-1:0]   din;
  logic [NUMRDPT-1:0]         read;
  logic [NUMRDPT*BITADDR-1:0] rd_adr;
  logic [NUMRDPT-1:0]         rd_vld;
  logic [NUMRDPT*WIDTH-1:0]   rd_dout;
  logic [NUMRDPT-1:0]         rd_fwrd;
  logic [NUMRDPT*BITPADR-1:0] rd_padr;
  int                         err_cnt;
  int                         miss_cnt;

  row_t        tbl [$];
  logic [31:0] lfsr      = 32'h817a;
  bit          tbl_built = 1'b0;

  stack_mem_top #(
    .SRAM_DELAY (SRAM_DELAY)
  ) i_dut (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .bw      (bw),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .rd_padr (rd_padr)
  );

  tb_shadow_check #(
    .SRAM_DELAY (SRAM_DELAY)
  ) i_chk (
    .clk      (clk),
    .rst      (rst),
    .write    (write),
    .wr_adr   (wr_adr),
    .bw       (bw),
    .din      (din),
    .read     (read),
    .rd_adr   (rd_adr),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_fwrd  (rd_fwrd),
    .rd_padr  (rd_padr),
    .err_cnt  (err_cnt),
    .miss_cnt (miss_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [WIDTH-1:0] w);
    for (int i = 0; i < WIDTH; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  task automatic add_row(input logic [1:0] wr, input int wa0, input logic [WIDTH-1:0] bw0,
                         input logic [WIDTH-1:0] d0, input int wa1,
                         input logic [WIDTH-1:0] bw1, input logic [WIDTH-1:0] d1,
                         input logic [1:0] rd, input int ra0, input int ra1, input bit rnd);
    tbl.push_back('{wr, wa0, bw0, d0, wa1, bw1, d1, rd, ra0, ra1, rnd});
  endtask

  task automatic drive_idle();
    write  = '0;
    wr_adr = '0;
    bw     = '0;
    din    = '0;
    read   = '0;
    rd_adr = '0;
  endtask

  task automatic apply_row(input row_t r);
    if (r.rnd) begin
      rand_word(r.d0);
      rand_word(r.d1);
    end
    write  = r.wr;
    wr_adr = {BITADDR'(r.wa1), BITADDR'(r.wa0)};
    bw     = {r.bw1, r.bw0};
    din    = {r.d1, r.d0};
    read   = r.rd;
    rd_adr = {BITADDR'(r.ra1), BITADDR'(r.ra0)};
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic build_table();
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b00, 0, 0, 0);
    add_row(2'b11, 10, FULL, 32'h1111_2222, 260, FULL, 32'h3333_4444, 2'b00, 0, 0, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 10, 260, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 260, 10, 0);
    add_row(2'b01, 10, 32'h0000_ffff, 32'habcd_5a5a, 0, '0, '0, 2'b00, 0, 0, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b01, 10, 0, 0);
    add_row(2'b01, 600, FULL, 32'h0f0f_0f0f, 0, '0, '0, 2'b00, 0, 0, 0);
    add_row(2'b11, 600, 32'hffff_0000, 32'haaaa_aaaa, 600, 32'h00ff_ff00, 32'h5555_5555,
            2'b00, 0, 0, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b10, 0, 600, 0);
    add_row(2'b01, 700, FULL, 32'hdead_beef, 0, '0, '0, 2'b11, 700, 10, 0);
    add_row(2'b11, 600, 32'h0000_00ff, 32'h1234_5678, 600, 32'h0000_ff00, 32'h8765_4321,
            2'b01, 600, 0, 0);
    add_row(2'b11, 0, FULL, '0, 249, FULL, '0, 2'b00, 0, 0, 1);
    add_row(2'b11, 250, FULL, '0, 499, FULL, '0, 2'b00, 0, 0, 1);
    add_row(2'b11, 500, FULL, '0, 749, FULL, '0, 2'b00, 0, 0, 1);
    add_row(2'b11, 750, FULL, '0, 999, FULL, '0, 2'b00, 0, 0, 1);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 0, 250, 0);       // Back to back from here.
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 249, 499, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 500, 750, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 749, 999, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 999, 0, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b11, 700, 600, 0);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b00, 0, 0, 0);
    add_row(2'b10, 0, '0, '0, 999, FULL, '0, 2'b11, 999, 749, 1);
    add_row(2'b00, 0, '0, '0, 0, '0, '0, 2'b01, 999, 0, 0);
  endtask

  initial begin
    rst = 1'b1;
    drive_idle();
    build_table();
    tbl_built = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (tbl[i]) begin
      apply_row(tbl[i]);
      @(posedge clk);
      #1;
    end
    drive_idle();
    repeat (SRAM_DELAY + 3) @(posedge clk);      // Last reads come back within this window.
    $display("Errors: %0d value mismatches, %0d missing or unexpected results",
             err_cnt, miss_cnt);
    if (err_cnt == 0 && miss_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (tbl_built == 1'b1);
    #((tbl.size() + SRAM_DELAY + 20) * CLK_PERIOD);
    $display("Watchdog timeout: the run did not reach its end in time.");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
